// File: tcdm_pkg.sv
// TCDM local group shared definitions
// Opcode encoding and word geometry used by the crossbars and banks

`default_nettype none

package tcdm_pkg;

  // ----------------------------------------
  // Word geometry
  // ----------------------------------------

  // One word size across the whole group
  parameter int unsigned DataWidth = 32;

  // One enable bit per byte lane
  parameter int unsigned StrbWidth = DataWidth / 8;

  // ----------------------------------------
  // Request opcodes
  // ----------------------------------------

  // Writes complete with a data-less response, just like reads
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

endpackage

`default_nettype wire

// File: tcdm_req_xbar.sv
// TCDM request crossbar
// Routes port requests to banks by the low address bits, round-robin per bank

`default_nettype none

module tcdm_req_xbar #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankDepth = 16,
  localparam int unsigned IniWidth     = (NumPorts > 1) ? $clog2(NumPorts) : 1,
  localparam int unsigned BankSelWidth = $clog2(NumBanks),
  localparam int unsigned RowWidth     = $clog2(BankDepth),
  localparam int unsigned AddrWidth    = $clog2(NumBanks * BankDepth)
) (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // Port side
  input  logic            [NumPorts-1:0]                   req_valid_i,
  input  logic            [NumPorts-1:0][AddrWidth-1:0]    req_addr_i,
  input  tcdm_pkg::op_e   [NumPorts-1:0]                   req_op_i,
  input  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]     req_wdata_i,
  input  logic [NumPorts-1:0][tcdm_pkg::StrbWidth-1:0]     req_be_i,
  output logic            [NumPorts-1:0]                   req_ready_o,
  // Bank side
  output logic            [NumBanks-1:0]                   bank_req_valid_o,
  output logic            [NumBanks-1:0][RowWidth-1:0]     bank_req_row_o,
  output tcdm_pkg::op_e   [NumBanks-1:0]                   bank_req_op_o,
  output logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]     bank_req_wdata_o,
  output logic [NumBanks-1:0][tcdm_pkg::StrbWidth-1:0]     bank_req_be_o,
  output logic            [NumBanks-1:0][IniWidth-1:0]     bank_req_ini_o,
  input  logic            [NumBanks-1:0]                   bank_req_ready_i
);

  // ----------------------------------------
  // Bank decode and arbitration
  // ----------------------------------------

  logic [NumBanks-1:0][NumPorts-1:0] hit;
  logic [NumBanks-1:0]               grant_valid;
  logic [NumBanks-1:0][IniWidth-1:0] grant_idx;
  logic [NumBanks-1:0][IniWidth-1:0] rr_q;

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        hit[b][p] = req_valid_i[p] &&
                    (req_addr_i[p][BankSelWidth-1:0] == BankSelWidth'(b));
      end
    end
  end

  // Search starts at the pointer and wraps around the ports
  always_comb begin
    int unsigned idx;
    idx = 0;
    for (int b = 0; b < NumBanks; b++) begin
      grant_valid[b] = 1'b0;
      grant_idx[b]   = '0;
      for (int k = 0; k < NumPorts; k++) begin
        idx = (int'(rr_q[b]) + k) % NumPorts;
        if (!grant_valid[b] && hit[b][idx]) begin
          grant_valid[b] = 1'b1;
          grant_idx[b]   = IniWidth'(idx);
        end
      end
    end
  end

  // Pointer moves past the winner on every accepted request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (grant_valid[b] && bank_req_ready_i[b]) begin
          rr_q[b] <= (grant_idx[b] == IniWidth'(NumPorts - 1)) ? '0 : grant_idx[b] + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Bank link mux and ready return
  // ----------------------------------------

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      bank_req_valid_o[b] = grant_valid[b];
      bank_req_row_o[b]   = req_addr_i[grant_idx[b]][AddrWidth-1:BankSelWidth];
      bank_req_op_o[b]    = req_op_i[grant_idx[b]];
      bank_req_wdata_o[b] = req_wdata_i[grant_idx[b]];
      bank_req_be_o[b]    = req_be_i[grant_idx[b]];
      bank_req_ini_o[b]   = grant_idx[b];
    end
  end

  // A port addresses one bank at a time, so at most one term is set
  always_comb begin
    req_ready_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int b = 0; b < NumBanks; b++) begin
        if (grant_valid[b] && grant_idx[b] == IniWidth'(p) && bank_req_ready_i[b]) begin
          req_ready_o[p] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tcdm_bank.sv
// TCDM memory bank
// Byte-writable word array with a one-entry response slot tagged by initiator

`default_nettype none

module tcdm_bank #(
  parameter int unsigned BankDepth = 16,
  parameter int unsigned NumPorts  = 4,
  localparam int unsigned RowWidth = $clog2(BankDepth),
  localparam int unsigned IniWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           req_valid_i,
  input  logic [RowWidth-1:0]            req_row_i,
  input  tcdm_pkg::op_e                  req_op_i,
  input  logic [tcdm_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [tcdm_pkg::StrbWidth-1:0] req_be_i,
  input  logic [IniWidth-1:0]            req_ini_i,
  output logic                           req_ready_o,
  output logic                           resp_valid_o,
  output logic [IniWidth-1:0]            resp_ini_o,
  output logic [tcdm_pkg::DataWidth-1:0] resp_rdata_o,
  input  logic                           resp_ready_i
);

  logic [tcdm_pkg::DataWidth-1:0] mem_q [BankDepth];

  logic                           resp_valid_q;
  logic [IniWidth-1:0]            resp_ini_q;
  logic [tcdm_pkg::DataWidth-1:0] resp_rdata_q;
  logic                           accept;

  // Slot free, or emptied this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_ini_q   <= req_ini_i;
      resp_rdata_q <= (req_op_i == tcdm_pkg::OP_READ) ? mem_q[req_row_i] : '0;
      if (req_op_i == tcdm_pkg::OP_WRITE) begin
        for (int i = 0; i < tcdm_pkg::StrbWidth; i++) begin
          if (req_be_i[i]) mem_q[req_row_i][i*8 +: 8] <= req_wdata_i[i*8 +: 8];
        end
      end
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = resp_ini_q;
  assign resp_rdata_o = resp_rdata_q;

endmodule

`default_nettype wire

// File: tcdm_resp_xbar.sv
// TCDM response crossbar
// Returns bank responses to their initiator ports, round-robin per port

`default_nettype none

module tcdm_resp_xbar #(
  parameter int unsigned NumPorts = 4,
  parameter int unsigned NumBanks = 4,
  localparam int unsigned IniWidth     = (NumPorts > 1) ? $clog2(NumPorts) : 1,
  localparam int unsigned BankSelWidth = $clog2(NumBanks)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Bank side
  input  logic [NumBanks-1:0]                           bank_resp_valid_i,
  input  logic [NumBanks-1:0][IniWidth-1:0]             bank_resp_ini_i,
  input  logic [NumBanks-1:0][tcdm_pkg::DataWidth-1:0]  bank_resp_rdata_i,
  output logic [NumBanks-1:0]                           bank_resp_ready_o,
  // Port side
  output logic [NumPorts-1:0]                           resp_valid_o,
  output logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  resp_rdata_o,
  input  logic [NumPorts-1:0]                           resp_ready_i
);

  // ----------------------------------------
  // Per-port arbitration over banks
  // ----------------------------------------

  logic [NumPorts-1:0][NumBanks-1:0]     hit;
  logic [NumPorts-1:0]                   grant_valid;
  logic [NumPorts-1:0][BankSelWidth-1:0] grant_idx;
  logic [NumPorts-1:0][BankSelWidth-1:0] rr_q;

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      for (int b = 0; b < NumBanks; b++) begin
        hit[p][b] = bank_resp_valid_i[b] && (bank_resp_ini_i[b] == IniWidth'(p));
      end
    end
  end

  always_comb begin
    int unsigned idx;
    idx = 0;
    for (int p = 0; p < NumPorts; p++) begin
      grant_valid[p] = 1'b0;
      grant_idx[p]   = '0;
      for (int k = 0; k < NumBanks; k++) begin
        idx = (int'(rr_q[p]) + k) % NumBanks;
        if (!grant_valid[p] && hit[p][idx]) begin
          grant_valid[p] = 1'b1;
          grant_idx[p]   = BankSelWidth'(idx);
        end
      end
    end
  end

  // Bank count is a power of two, so the increment wraps by itself
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        if (grant_valid[p] && resp_ready_i[p]) begin
          rr_q[p] <= grant_idx[p] + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Data forward and bank ready
  // ----------------------------------------

  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      resp_valid_o[p] = grant_valid[p];
      resp_rdata_o[p] = bank_resp_rdata_i[grant_idx[p]];
    end
  end

  // Each bank names one port, so only that port's grant can release it
  always_comb begin
    bank_resp_ready_o = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (grant_valid[p] && grant_idx[p] == BankSelWidth'(b) && resp_ready_i[p]) begin
          bank_resp_ready_o[b] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tcdm_local_group.sv
// TCDM local group top level
// Request crossbar, bank array and response crossbar

`default_nettype none

module tcdm_local_group #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankDepth = 16,
  localparam int unsigned IniWidth  = (NumPorts > 1) ? $clog2(NumPorts) : 1,
  localparam int unsigned RowWidth  = $clog2(BankDepth),
  localparam int unsigned AddrWidth = $clog2(NumBanks * BankDepth)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  // Request ports
  input  logic          [NumPorts-1:0]                  req_valid_i,
  input  logic          [NumPorts-1:0][AddrWidth-1:0]   req_addr_i,
  input  tcdm_pkg::op_e [NumPorts-1:0]                  req_op_i,
  input  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  req_wdata_i,
  input  logic [NumPorts-1:0][tcdm_pkg::StrbWidth-1:0]  req_be_i,
  output logic          [NumPorts-1:0]                  req_ready_o,
  // Response ports
  output logic          [NumPorts-1:0]                  resp_valid_o,
  output logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0]  resp_rdata_o,
  input  logic          [NumPorts-1:0]                  resp_ready_i
);

  // Crossbar to bank links
  logic          [NumBanks-1:0]                          bank_req_valid;
  logic          [NumBanks-1:0][RowWidth-1:0]            bank_req_row;
  tcdm_pkg::op_e [NumBanks-1:0]                          bank_req_op;
  logic          [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_req_wdata;
  logic          [NumBanks-1:0][tcdm_pkg::StrbWidth-1:0] bank_req_be;
  logic          [NumBanks-1:0][IniWidth-1:0]            bank_req_ini;
  logic          [NumBanks-1:0]                          bank_req_ready;
  // Bank to crossbar links
  logic          [NumBanks-1:0]                          bank_resp_valid;
  logic          [NumBanks-1:0][IniWidth-1:0]            bank_resp_ini;
  logic          [NumBanks-1:0][tcdm_pkg::DataWidth-1:0] bank_resp_rdata;
  logic          [NumBanks-1:0]                          bank_resp_ready;

  tcdm_req_xbar #(
    .NumPorts (NumPorts ),
    .NumBanks (NumBanks ),
    .BankDepth(BankDepth)
  ) i_req_xbar (
    .clk_i           (clk_i         ),
    .rst_i           (rst_i         ),
    .req_valid_i     (req_valid_i   ),
    .req_addr_i      (req_addr_i    ),
    .req_op_i        (req_op_i      ),
    .req_wdata_i     (req_wdata_i   ),
    .req_be_i        (req_be_i      ),
    .req_ready_o     (req_ready_o   ),
    .bank_req_valid_o(bank_req_valid),
    .bank_req_row_o  (bank_req_row  ),
    .bank_req_op_o   (bank_req_op   ),
    .bank_req_wdata_o(bank_req_wdata),
    .bank_req_be_o   (bank_req_be   ),
    .bank_req_ini_o  (bank_req_ini  ),
    .bank_req_ready_i(bank_req_ready)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    tcdm_bank #(
      .BankDepth(BankDepth),
      .NumPorts (NumPorts )
    ) i_bank (
      .clk_i       (clk_i             ),
      .rst_i       (rst_i             ),
      .req_valid_i (bank_req_valid[b] ),
      .req_row_i   (bank_req_row[b]   ),
      .req_op_i    (bank_req_op[b]    ),
      .req_wdata_i (bank_req_wdata[b] ),
      .req_be_i    (bank_req_be[b]    ),
      .req_ini_i   (bank_req_ini[b]   ),
      .req_ready_o (bank_req_ready[b] ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ini_o  (bank_resp_ini[b]  ),
      .resp_rdata_o(bank_resp_rdata[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end : gen_banks

  tcdm_resp_xbar #(
    .NumPorts(NumPorts),
    .NumBanks(NumBanks)
  ) i_resp_xbar (
    .clk_i            (clk_i          ),
    .rst_i            (rst_i          ),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ini_i  (bank_resp_ini  ),
    .bank_resp_rdata_i(bank_resp_rdata),
    .bank_resp_ready_o(bank_resp_ready),
    .resp_valid_o     (resp_valid_o   ),
    .resp_rdata_o     (resp_rdata_o   ),
    .resp_ready_i     (resp_ready_i   )
  );

endmodule

`default_nettype wire

// File: tcdm_group_checker.sv
// TCDM group response checker
// Compares each completed response with the word expected at acceptance

`default_nettype none

module tcdm_group_checker #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [NumPorts-1:0]                          resp_valid_i,
  input  logic [NumPorts-1:0]                          resp_ready_i,
  input  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] resp_rdata_i,
  output int                                           error_count_o
);

  logic [NumPorts-1:0]                          pending;
  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] expected;
  int total_checks;
  int total_errors;
  int test_checks;
  int test_errors;
  int test_count;

  initial begin
    pending      = '0;
    expected     = '0;
    total_checks = 0;
    total_errors = 0;
    test_checks  = 0;
    test_errors  = 0;
    test_count   = 0;
  end

  assign error_count_o = total_errors;

  task automatic flag_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    total_errors++;
    test_errors++;
  endtask

  task automatic expect_response(input int port, input logic [tcdm_pkg::DataWidth-1:0] data);
    pending[port]  = 1'b1;
    expected[port] = data;
  endtask

  // ----------------------------------------
  // Response compare
  // ----------------------------------------

  // Handshake signals are settled at the falling edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (resp_valid_i[p] && resp_ready_i[p]) begin
          if (!pending[p]) begin
            flag_failure($sformatf("response on port %0d with nothing outstanding", p));
          end else begin
            pending[p] = 1'b0;
            total_checks++;
            test_checks++;
            if (resp_rdata_i[p] !== expected[p]) begin
              $display("MISMATCH at %0t: port %0d returned %h, expected %h",
                       $time, p, resp_rdata_i[p], expected[p]);
              total_errors++;
              test_errors++;
            end
          end
        end
      end
    end
  end

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %0d (%s): %0d responses checked, %0d errors, %s",
             test_count, name, test_checks, test_errors, (test_errors == 0) ? "ok" : "failed");
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic print_summary(input int assertion_failures);
    $display("Summary: %0d tests, %0d responses checked, %0d checker errors, %0d assertion failures",
             test_count, total_checks, total_errors, assertion_failures);
  endtask

endmodule

`default_nettype wire

// File: tcdm_group_assertions.sv
// TCDM local group handshake assertions
// Bound into the top level, covers reset state and valid/ready stability

`default_nettype none

module tcdm_group_assertions #(
  parameter int unsigned NumPorts  = 4,
  parameter int unsigned NumBanks  = 4,
  parameter int unsigned BankDepth = 16,
  localparam int unsigned AddrWidth = $clog2(NumBanks * BankDepth)
) (
  input logic                                         clk_i,
  input logic                                         rst_i,
  input logic          [NumPorts-1:0]                 req_valid_i,
  input logic          [NumPorts-1:0][AddrWidth-1:0]  req_addr_i,
  input tcdm_pkg::op_e [NumPorts-1:0]                 req_op_i,
  input logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] req_wdata_i,
  input logic [NumPorts-1:0][tcdm_pkg::StrbWidth-1:0] req_be_i,
  input logic          [NumPorts-1:0]                 req_ready_o,
  input logic          [NumPorts-1:0]                 resp_valid_o,
  input logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] resp_rdata_o,
  input logic          [NumPorts-1:0]                 resp_ready_i
);

  int failures = 0;

  reset_clears_resp: assert property (@(posedge clk_i) rst_i |=> (resp_valid_o == '0))
    else begin
      $error("response valid seen right after reset");
      failures++;
    end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_ports
    // Stalled request keeps its fields
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_i[p] && !req_ready_o[p] |=> req_valid_i[p] && $stable(req_addr_i[p]) &&
        $stable(req_op_i[p]) && $stable(req_wdata_i[p]) && $stable(req_be_i[p]))
      else begin
        $error("request on port %0d changed while stalled", p);
        failures++;
      end

    resp_held: assert property (@(posedge clk_i) disable iff (rst_i)
        resp_valid_o[p] && !resp_ready_i[p] |=> resp_valid_o[p] && $stable(resp_rdata_o[p]))
      else begin
        $error("response on port %0d dropped or changed under back-pressure", p);
        failures++;
      end
  end

endmodule

bind tcdm_local_group tcdm_group_assertions #(
  .NumPorts (NumPorts ),
  .NumBanks (NumBanks ),
  .BankDepth(BankDepth)
) i_assertions (
  .clk_i       (clk_i       ),
  .rst_i       (rst_i       ),
  .req_valid_i (req_valid_i ),
  .req_addr_i  (req_addr_i  ),
  .req_op_i    (req_op_i    ),
  .req_wdata_i (req_wdata_i ),
  .req_be_i    (req_be_i    ),
  .req_ready_o (req_ready_o ),
  .resp_valid_o(resp_valid_o),
  .resp_rdata_o(resp_rdata_o),
  .resp_ready_i(resp_ready_i)
);

`default_nettype wire

// File: tb_tcdm_local_group.sv
// TCDM local group testbench
// Drives all request ports against a reference memory, the checker compares responses

`default_nettype none

module tb_tcdm_local_group;

  localparam int unsigned NumPorts  = 4;
  localparam int unsigned NumBanks  = 4;
  localparam int unsigned BankDepth = 16;
  localparam int unsigned NumWords  = NumBanks * BankDepth;
  localparam int unsigned AddrWidth = $clog2(NumWords);

  localparam int ClkPeriod        = 20;
  localparam int DriveDelay       = 2;
  localparam int PartialWrites    = 6;
  localparam int ContentionRounds = 8;
  localparam int RandomRounds     = 40;
  localparam int HotBank          = 2;
  localparam int CyclesPerAccess  = 16;
  localparam int TotalAccesses    = 2 + (PartialWrites + 2) + 2 * NumWords +
                                    NumPorts * (ContentionRounds + RandomRounds);
  localparam int TimeoutCycles    = TotalAccesses * CyclesPerAccess + 10;

  // Port job kinds
  localparam int JobFill       = 0;
  localparam int JobReadBack   = 1;
  localparam int JobContention = 2;
  localparam int JobRandom     = 3;

  logic                                         clk;
  logic                                         rst;
  logic          [NumPorts-1:0]                 req_valid;
  logic          [NumPorts-1:0][AddrWidth-1:0]  req_addr;
  tcdm_pkg::op_e [NumPorts-1:0]                 req_op;
  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] req_wdata;
  logic [NumPorts-1:0][tcdm_pkg::StrbWidth-1:0] req_be;
  logic          [NumPorts-1:0]                 req_ready;
  logic          [NumPorts-1:0]                 resp_valid;
  logic [NumPorts-1:0][tcdm_pkg::DataWidth-1:0] resp_rdata;
  logic          [NumPorts-1:0]                 resp_ready;

  logic [tcdm_pkg::DataWidth-1:0] ref_mem [NumWords];
  integer seed;
  logic   backpressure;
  int     jobs_done;
  int     checker_errors;
  int     failures;

  tcdm_local_group #(
    .NumPorts (NumPorts ),
    .NumBanks (NumBanks ),
    .BankDepth(BankDepth)
  ) UUT (
    .clk_i       (clk       ),
    .rst_i       (rst       ),
    .req_valid_i (req_valid ),
    .req_addr_i  (req_addr  ),
    .req_op_i    (req_op    ),
    .req_wdata_i (req_wdata ),
    .req_be_i    (req_be    ),
    .req_ready_o (req_ready ),
    .resp_valid_o(resp_valid),
    .resp_rdata_o(resp_rdata),
    .resp_ready_i(resp_ready)
  );

  tcdm_group_checker #(
    .NumPorts(NumPorts)
  ) i_checker (
    .clk_i        (clk           ),
    .rst_i        (rst           ),
    .resp_valid_i (resp_valid    ),
    .resp_ready_i (resp_ready    ),
    .resp_rdata_i (resp_rdata    ),
    .error_count_o(checker_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("ERROR: watchdog expired after %0d cycles, an access never completed",
             TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Random back-pressure only while enabled
  initial begin
    forever begin
      @(posedge clk);
      #DriveDelay;
      if (backpressure) resp_ready = NumPorts'($random(seed));
      else resp_ready = '1;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Applies a write byte by byte, or returns the stored word for a read
  function automatic logic [tcdm_pkg::DataWidth-1:0] ref_access(
      input int unsigned addr, input tcdm_pkg::op_e op,
      input logic [tcdm_pkg::DataWidth-1:0] wdata, input logic [tcdm_pkg::StrbWidth-1:0] be);
    logic [tcdm_pkg::DataWidth-1:0] result;
    result = '0;
    if (op == tcdm_pkg::OP_WRITE) begin
      for (int i = 0; i < tcdm_pkg::StrbWidth; i++) begin
        if (be[i]) ref_mem[addr][i*8 +: 8] = wdata[i*8 +: 8];
      end
    end else begin
      result = ref_mem[addr];
    end
    return result;
  endfunction

  function automatic logic [tcdm_pkg::DataWidth-1:0] fill_word(input int unsigned addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic tcdm_pkg::op_e random_op();
    return ($random(seed) & 1) ? tcdm_pkg::OP_WRITE : tcdm_pkg::OP_READ;
  endfunction

  function automatic int grants_to_others(input int p, input int unsigned bank);
    int count;
    count = 0;
    for (int q = 0; q < NumPorts; q++) begin
      if (q != p && req_valid[q] && req_ready[q] && (int'(req_addr[q]) % NumBanks) == bank) begin
        count++;
      end
    end
    return count;
  endfunction

  // ----------------------------------------
  // Port driving
  // ----------------------------------------

  // Starts and ends a drive delay after a rising edge
  task automatic issue_access(input int p, input int unsigned addr, input tcdm_pkg::op_e op,
      input logic [tcdm_pkg::DataWidth-1:0] wdata, input logic [tcdm_pkg::StrbWidth-1:0] be);
    logic [tcdm_pkg::DataWidth-1:0] expected;
    int others;
    req_valid[p] = 1'b1;
    req_addr[p]  = AddrWidth'(addr);
    req_op[p]    = op;
    req_wdata[p] = wdata;
    req_be[p]    = be;
    others       = 0;
    @(negedge clk);
    while (!req_ready[p]) begin
      others += grants_to_others(p, addr % NumBanks);
      @(negedge clk);
    end
    if (others >= NumPorts) begin
      i_checker.flag_failure($sformatf("port %0d waited through %0d grants of bank %0d",
                                       p, others, addr % NumBanks));
    end
    expected = ref_access(addr, op, wdata, be);
    i_checker.expect_response(p, expected);
    @(posedge clk);
    #DriveDelay;
    req_valid[p] = 1'b0;
    @(negedge clk);
    while (!(resp_valid[p] && resp_ready[p])) @(negedge clk);
    @(posedge clk);
    #DriveDelay;
  endtask

  task automatic port_job(input int kind, input int p);
    int unsigned addr;
    int unsigned span;
    span = NumWords / NumPorts;
    case (kind)
      JobFill, JobReadBack: begin
        for (int i = 0; i < span; i++) begin
          addr = p * span + i;
          if (kind == JobFill) issue_access(p, addr, tcdm_pkg::OP_WRITE, fill_word(addr), '1);
          else issue_access(p, addr, tcdm_pkg::OP_READ, '0, '0);
        end
      end
      JobContention: begin
        repeat (ContentionRounds) begin
          addr = ($unsigned($random(seed)) % BankDepth) * NumBanks + HotBank;
          issue_access(p, addr, random_op(), 32'($random(seed)), '1);
        end
      end
      default: begin
        repeat (RandomRounds) begin
          addr = $unsigned($random(seed)) % NumWords;
          issue_access(p, addr, random_op(), 32'($random(seed)), 4'($random(seed)));
        end
      end
    endcase
    jobs_done++;
  endtask

  task automatic run_ports(input int kind);
    jobs_done = 0;
    for (int p = 0; p < NumPorts; p++) begin
      fork
        automatic int port = p;
        port_job(kind, port);
      join_none
    end
    wait (jobs_done == NumPorts);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    seed         = 32'hb73;
    rst          = 1'b1;
    backpressure = 1'b0;
    req_valid    = '0;
    req_addr     = '0;
    req_wdata    = '0;
    req_be       = '0;
    resp_ready   = '1;
    for (int p = 0; p < NumPorts; p++) req_op[p] = tcdm_pkg::OP_READ;
    for (int a = 0; a < NumWords; a++) ref_mem[a] = '0;

    repeat (2) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    @(posedge clk);
    #DriveDelay;

    issue_access(0, 5, tcdm_pkg::OP_WRITE, 32'hcafe_f00d, '1);
    issue_access(0, 5, tcdm_pkg::OP_READ, '0, '0);
    i_checker.finish_test("write then read back");

    // Full write first so every byte is known
    issue_access(1, 22, tcdm_pkg::OP_WRITE, 32'h1122_3344, '1);
    repeat (PartialWrites) begin
      issue_access(1, 22, tcdm_pkg::OP_WRITE, 32'($random(seed)), 4'($random(seed)));
    end
    issue_access(1, 22, tcdm_pkg::OP_READ, '0, '0);
    i_checker.finish_test("partial byte writes");

    run_ports(JobFill);
    run_ports(JobReadBack);
    i_checker.finish_test("address sweep");

    run_ports(JobContention);
    i_checker.finish_test("same-bank contention");

    backpressure = 1'b1;
    run_ports(JobRandom);
    backpressure = 1'b0;
    i_checker.finish_test("random traffic with back-pressure");

    i_checker.print_summary(UUT.i_assertions.failures);
    failures = checker_errors + UUT.i_assertions.failures;
    if (failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
tcdm_pkg.sv
tcdm_req_xbar.sv
tcdm_bank.sv
tcdm_resp_xbar.sv
tcdm_local_group.sv
tcdm_group_checker.sv
tcdm_group_assertions.sv
tb_tcdm_local_group.sv

// File: run_sim.sh
#!/bin/sh
# Build the TCDM local group testbench with Verilator and run it.
# The run passes only if the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_tcdm_local_group
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_tcdm_local_group)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
